//--- list.f
+incdir+common
common/sdcard_cmd_pkg.sv
common/sdcard_state_pkg.sv
hdl/sdcard_crc7.sv
cmdio/sdcard_cmd_rx.sv
cmdio/sdcard_cmd_tx.sv
hdl/sdcard_req_fifo.sv
ctrl/sdcard_ctrl.sv
hdl/sdcard_top.sv
tb/sdcard_clkgen.sv
tb/tb_sdcard.sv

//--- Makefile
# Verilator flow for the SD card command-line model

VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_sdcard
FILELIST  = list.f
OBJDIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass message shows up in the simulator output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(OBJDIR)

//--- tb/tb_sdcard.sv
/* testbench for the SD card command line, acts as the host
   sends CMD0, CMD8, CMD55 and ACMD41 frames and checks every response bit */

`timescale 1ns/10ps

`include "sdcard_consts.svh"

module tb_sdcard;

    localparam int CLK_PERIOD_NS = 100;
    localparam int RESET_CYCLES  = 10;
    localparam int NCR_MAX       = 64;      // longest wait for a response start bit
    localparam int NUM_CMDS      = 16;
    localparam int TIMEOUT_NS    = (NUM_CMDS * 150 + RESET_CYCLES) * CLK_PERIOD_NS;

    logic        clk;
    logic        rst;
    logic        cmd_in;
    logic        cmd_out;
    logic        cmd_dir;
    logic        resp_window = 1'b0;        // high while a response is due
    logic [15:0] lfsr        = 16'd91;
    int          errors      = 0;
    int          checks      = 0;

    sdcard_clkgen #(.PERIOD_NS(CLK_PERIOD_NS)) clkgen0 (
        .o_clk(clk)
    );

    sdcard_top sdcard_top_i (
        .i_sclk(clk),
        .i_rst(rst),
        .i_cmd(cmd_in),
        .o_cmd(cmd_out),
        .o_cmd_dir(cmd_dir)
    );

    // galois form, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // x^7 + x^3 + 1, msb of the frame first
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--)
        begin
            fb = bits[i] ^ c[6];
            c = {c[5:0], 1'b0};
            if (fb)
                c = c ^ 7'h09;
        end
        return c;
    endfunction

    function automatic logic [31:0] r1_word(input logic [3:0] st, input logic illegal,
                                            input logic app);
        return (32'(illegal) << sdcard_state_pkg::R1_ILLEGAL_CMD_BIT)
             | (32'(app) << sdcard_state_pkg::R1_APP_CMD_BIT)
             | (32'(st) << sdcard_state_pkg::R1_STATE_LSB);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic drive_frame(input logic [5:0] idx, input logic [31:0] arg,
                               input logic [6:0] crc_flip);
        logic [39:0] head;
        logic [47:0] frame;
        head = {2'b01, idx, arg};
        frame = {head, crc7_of(head) ^ crc_flip, 1'b1};
        for (int i = 47; i >= 0; i--)
        begin
            @(posedge clk);
            cmd_in <= frame[i];
        end
        @(posedge clk);             // card samples the end bit here
        cmd_in <= 1'b1;
    endtask

    task automatic capture_response(output logic [47:0] r, output logic got);
        int wait_cnt;
        r = '1;
        got = 1'b0;
        wait_cnt = 0;
        resp_window = 1'b1;
        @(negedge clk);
        while (cmd_dir === 1'b1 && wait_cnt < NCR_MAX)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (cmd_dir !== 1'b0)
        begin
            errors++;
            $display("no response started within %0d cycles, at %0t", NCR_MAX, $time);
        end
        else
        begin
            got = 1'b1;
            for (int i = 47; i >= 0; i--)
            begin
                check_val("o_cmd_dir during response", 32'(cmd_dir), 32'd0);
                r[i] = cmd_out;
                @(negedge clk);
            end
            check_val("o_cmd_dir after end bit", 32'(cmd_dir), 32'd1);
        end
        @(posedge clk);
        resp_window = 1'b0;
    endtask

    task automatic check_resp(input logic [47:0] r, input logic [5:0] idx,
                              input logic [31:0] data, input logic r3);
        check_val("start bit", 32'(r[47]), 32'd0);
        check_val("transmission bit", 32'(r[46]), 32'd0);
        check_val("response index", 32'(r[45:40]), r3 ? 32'h3f : 32'(idx));
        check_val("response data", r[39:8], data);
        check_val("response crc7", 32'(r[7:1]), r3 ? 32'h7f : 32'(crc7_of(r[47:8])));
        check_val("end bit", 32'(r[0]), 32'd1);
    endtask

    task automatic expect_response(input logic [5:0] idx, input logic [31:0] arg,
                                   input logic [31:0] data, input logic r3);
        logic [47:0] r;
        logic        got;
        drive_frame(idx, arg, 7'h00);
        capture_response(r, got);
        if (got)
            check_resp(r, idx, data, r3);
    endtask

    // a response here trips the line monitor
    task automatic expect_no_response(input logic [5:0] idx, input logic [31:0] arg,
                                      input logic [6:0] crc_flip);
        drive_frame(idx, arg, crc_flip);
        repeat (NCR_MAX + 2) @(negedge clk);
    endtask

    // released line idles high
    assert property (@(negedge clk) disable iff (rst !== 1'b0)
                     cmd_dir !== 1'b1 || cmd_out === 1'b1)
    else
    begin
        errors++;
        $display("error at %0t: o_cmd is %b while released, expected 1", $time, cmd_out);
    end

    // card owns the line only while a response is due
    assert property (@(negedge clk) disable iff (rst !== 1'b0)
                     resp_window || cmd_dir === 1'b1)
    else
    begin
        errors++;
        $display("card drove the line at %0t when no response was due", $time);
    end

    initial
    begin : watchdog
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, %0d checks, %0d errors",
                 TIMEOUT_NS, checks, errors);
        $display("Something failed");
        $finish;
    end

    initial
    begin : host
        sdcard_cmd_pkg::sdcard_cmd_arg_u arg;
        logic [31:0] rnd;
        logic        hcs;
        logic        busy;
        rst    <= 1'b1;
        cmd_in <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val("o_cmd after reset", 32'(cmd_out), 32'd1);
        check_val("o_cmd_dir after reset", 32'(cmd_dir), 32'd1);
        // known frames 40 00 00 00 00 95 and 48 00 00 01 aa 87
        check_val("crc7 of CMD0", 32'(crc7_of(40'h40_0000_0000)), 32'h4a);
        check_val("crc7 of CMD8", 32'(crc7_of(40'h48_0000_01aa)), 32'h43);

        take_bits(8, rnd);
        arg = '0;
        arg.if_cond.vhs = `SDCARD_VHS;
        arg.if_cond.check_pattern = rnd[7:0];
        expect_response(sdcard_cmd_pkg::CMD_SEND_IF_COND, arg,
                        {20'h0, `SDCARD_VHS, rnd[7:0]}, 1'b0);
        arg.if_cond.vhs = 4'h2;                 // unsupported supply, card stays silent
        expect_no_response(sdcard_cmd_pkg::CMD_SEND_IF_COND, arg, 7'h00);

        // power-up loop, one pass past the point where busy sets
        for (int n = 1; n <= `SDCARD_POWERUP_DONE_DELAY + 1; n++)
        begin
            take_bits(32, rnd);
            expect_response(sdcard_cmd_pkg::CMD_APP_CMD, rnd,
                            r1_word((n > `SDCARD_POWERUP_DONE_DELAY) ? sdcard_state_pkg::READY
                                                                     : sdcard_state_pkg::IDLE,
                                    1'b0, 1'b1), 1'b0);
            take_bits(1, rnd);
            hcs = rnd[0];
            take_bits(24, rnd);
            arg = '0;
            arg.op_cond.hcs = hcs;
            arg.op_cond.vdd_window = rnd[23:0];
            busy = (n >= `SDCARD_POWERUP_DONE_DELAY);
            expect_response(sdcard_cmd_pkg::ACMD_SD_SEND_OP_COND, arg,
                            {busy, busy & hcs, 6'h0, `SDCARD_VDD_VOLTAGE_WINDOW}, 1'b1);
        end

        // dropped CMD55 leaves the next 41 without its app prefix
        expect_no_response(sdcard_cmd_pkg::CMD_APP_CMD, 32'h0, 7'h04);
        take_bits(32, rnd);
        expect_response(sdcard_cmd_pkg::ACMD_SD_SEND_OP_COND, rnd,
                        r1_word(sdcard_state_pkg::READY, 1'b1, 1'b0), 1'b0);
        expect_response(6'd13, rnd, r1_word(sdcard_state_pkg::READY, 1'b1, 1'b0), 1'b0);

        expect_no_response(sdcard_cmd_pkg::CMD_GO_IDLE, 32'h0, 7'h00);
        expect_response(sdcard_cmd_pkg::CMD_APP_CMD, rnd,
                        r1_word(sdcard_state_pkg::IDLE, 1'b0, 1'b1), 1'b0);
        arg = '0;
        arg.op_cond.hcs = 1'b1;
        arg.op_cond.vdd_window = rnd[23:0];
        expect_response(sdcard_cmd_pkg::ACMD_SD_SEND_OP_COND, arg,
                        {2'b00, 6'h0, `SDCARD_VDD_VOLTAGE_WINDOW}, 1'b1);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- tb/sdcard_clkgen.sv
/* free-running testbench clock, 100 ns period by default */

`timescale 1ns/10ps

module sdcard_clkgen #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);

    initial
    begin
        o_clk = 1'b0;
    end

    always #(PERIOD_NS / 2) o_clk = ~o_clk;   // low first half, rising edge at 50 ns

endmodule

//--- hdl/sdcard_top.sv
/* SD card command-line model, card side
   host frames come in on i_cmd, responses leave on o_cmd while o_cmd_dir is low */

`timescale 1ns/10ps

module sdcard_top (
    input  logic i_sclk,
    input  logic i_rst,
    input  logic i_cmd,
    output logic o_cmd,
    output logic o_cmd_dir
);

    logic                             w_rx_valid;
    sdcard_cmd_pkg::sdcard_cmd_req_t  wb_rx_req;
    logic                             w_rx_ready;
    logic                             w_req_valid;
    sdcard_cmd_pkg::sdcard_cmd_req_t  wb_req;
    logic                             w_req_ready;
    logic                             w_resp_valid;
    sdcard_cmd_pkg::sdcard_cmd_resp_t wb_resp;
    logic                             w_resp_ready;
    logic                             w_line_busy;

    sdcard_cmd_rx rx0 (
        .i_clk(i_sclk),
        .i_rst(i_rst),
        .i_cmd(i_cmd),
        .i_line_busy(w_line_busy),
        .o_req_valid(w_rx_valid),
        .o_req(wb_rx_req),
        .i_req_ready(w_rx_ready)
    );

    sdcard_req_fifo fifo0 (
        .i_clk(i_sclk),
        .i_rst(i_rst),
        .i_wr_valid(w_rx_valid),
        .i_wr_data(wb_rx_req),
        .o_wr_ready(w_rx_ready),
        .o_rd_valid(w_req_valid),
        .o_rd_data(wb_req),
        .i_rd_ready(w_req_ready)
    );

    sdcard_ctrl ctrl0 (
        .i_clk(i_sclk),
        .i_rst(i_rst),
        .i_req_valid(w_req_valid),
        .i_req(wb_req),
        .o_req_ready(w_req_ready),
        .o_resp_valid(w_resp_valid),
        .o_resp(wb_resp),
        .i_resp_ready(w_resp_ready)
    );

    sdcard_cmd_tx tx0 (
        .i_clk(i_sclk),
        .i_rst(i_rst),
        .i_resp_valid(w_resp_valid),
        .i_resp(wb_resp),
        .o_resp_ready(w_resp_ready),
        .o_cmd(o_cmd),
        .o_cmd_dir(o_cmd_dir),
        .o_line_busy(w_line_busy)
    );

endmodule

//--- ctrl/sdcard_ctrl.sv
/* card controller, decodes CMD0, CMD8, CMD55 and ACMD41 and builds responses
   takes requests from the FIFO, holds each response until the transmitter takes it */

`timescale 1ns/10ps

`include "sdcard_consts.svh"

module sdcard_ctrl (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_req_valid,
    input  sdcard_cmd_pkg::sdcard_cmd_req_t  i_req,
    output logic                             o_req_ready,
    output logic                             o_resp_valid,
    output sdcard_cmd_pkg::sdcard_cmd_resp_t o_resp,
    input  logic                             i_resp_ready
);

    sdcard_state_pkg::sdcard_state_e state;
    sdcard_state_pkg::sdcard_state_e state_next;
    logic                            app_cmd;      // last accepted command was CMD55
    logic [7:0]                      acmd41_cnt;
    logic [7:0]                      cnt_next;
    logic [7:0]                      cnt_inc;
    logic                            pwr_done;
    logic                            accept;
    logic                            respond;
    sdcard_cmd_pkg::sdcard_cmd_resp_t resp_next;

    function automatic logic [31:0] r1_status(
        input sdcard_state_pkg::sdcard_state_e st,
        input logic                            illegal,
        input logic                            app
    );
        logic [31:0] s;
        s = '0;
        s[sdcard_state_pkg::R1_ILLEGAL_CMD_BIT] = illegal;
        s[sdcard_state_pkg::R1_APP_CMD_BIT] = app;
        s[sdcard_state_pkg::R1_STATE_LSB +: 4] = st;
        return s;
    endfunction

    assign o_req_ready = !o_resp_valid;
    assign accept      = i_req_valid && o_req_ready;

    assign cnt_inc  = (acmd41_cnt == 8'hff) ? acmd41_cnt : acmd41_cnt + 8'd1;  // saturating
    assign pwr_done = (cnt_inc >= 8'(`SDCARD_POWERUP_DONE_DELAY));

    always_comb
    begin
        // anything not matched below is an illegal command
        respond           = 1'b1;
        state_next        = state;
        cnt_next          = acmd41_cnt;
        resp_next.kind    = sdcard_cmd_pkg::RESP_R1;
        resp_next.cmd_idx = i_req.cmd_idx;
        resp_next.data    = r1_status(state, 1'b1, 1'b0);
        case (i_req.cmd_idx)
            sdcard_cmd_pkg::CMD_GO_IDLE:
            begin
                respond    = 1'b0;
                state_next = sdcard_state_pkg::IDLE;
                cnt_next   = '0;
            end
            sdcard_cmd_pkg::CMD_SEND_IF_COND:
            begin
                respond        = (i_req.arg.if_cond.vhs == `SDCARD_VHS);  // silent on mismatch
                resp_next.kind = sdcard_cmd_pkg::RESP_R7;
                resp_next.data = {20'h0, i_req.arg.if_cond.vhs, i_req.arg.if_cond.check_pattern};
            end
            sdcard_cmd_pkg::CMD_APP_CMD:
                resp_next.data = r1_status(state, 1'b0, 1'b1);
            sdcard_cmd_pkg::ACMD_SD_SEND_OP_COND:
                if (app_cmd)
                begin
                    cnt_next       = cnt_inc;
                    resp_next.kind = sdcard_cmd_pkg::RESP_R3;
                    // OCR: busy bit set once power-up is done, ccs only valid then
                    resp_next.data = {pwr_done, pwr_done & i_req.arg.op_cond.hcs, 6'h0,
                                      `SDCARD_VDD_VOLTAGE_WINDOW};
                    if (pwr_done)
                        state_next = sdcard_state_pkg::READY;
                end
            default:
                respond = 1'b1;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            state        <= sdcard_state_pkg::IDLE;
            app_cmd      <= 1'b0;
            acmd41_cnt   <= '0;
            o_resp_valid <= 1'b0;
        end
        else if (accept)
        begin
            state        <= state_next;
            acmd41_cnt   <= cnt_next;
            app_cmd      <= (i_req.cmd_idx == sdcard_cmd_pkg::CMD_APP_CMD);
            o_resp_valid <= respond;
        end
        else if (i_resp_ready)
            o_resp_valid <= 1'b0;     // transmitter took it
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
            o_resp <= resp_next;
    end

endmodule

//--- hdl/sdcard_req_fifo.sv
/* small synchronous FIFO of command requests, valid/ready on both sides
   written entries show at the read side one cycle later */

`timescale 1ns/10ps

`include "sdcard_consts.svh"

module sdcard_req_fifo #(
    parameter int DEPTH = `SDCARD_REQ_FIFO_DEPTH
) (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_wr_valid,
    input  sdcard_cmd_pkg::sdcard_cmd_req_t i_wr_data,
    output logic                            o_wr_ready,
    output logic                            o_rd_valid,
    output sdcard_cmd_pkg::sdcard_cmd_req_t o_rd_data,
    input  logic                            i_rd_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    sdcard_cmd_pkg::sdcard_cmd_req_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // wraps for any depth, not only powers of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign o_wr_ready = (count != CNT_W'(DEPTH));
    assign o_rd_valid = (count != '0);
    assign do_wr      = i_wr_valid && o_wr_ready;
    assign do_rd      = o_rd_valid && i_rd_ready;
    assign o_rd_data  = mem[rd_ptr];

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= i_wr_data;
    end

endmodule

//--- cmdio/sdcard_cmd_tx.sv
/* command-line transmitter, sends one response frame with its CRC7
   after a short gap; o_line_busy keeps the receiver off the line meanwhile */

`timescale 1ns/10ps

`include "sdcard_consts.svh"

module sdcard_cmd_tx (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_resp_valid,
    input  sdcard_cmd_pkg::sdcard_cmd_resp_t i_resp,
    output logic                             o_resp_ready,
    output logic                             o_cmd,
    output logic                             o_cmd_dir,
    output logic                             o_line_busy
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_GAP,
        TX_SEND
    } tx_state_e;

    localparam logic [5:0] GAP_LAST  = 6'd1;   // two idle cycles before the start bit
    localparam logic [5:0] CRC_FIRST = 6'(`SDCARD_FRAME_BITS - 8);
    localparam logic [5:0] END_BIT   = 6'(`SDCARD_FRAME_BITS - 1);

    tx_state_e   state;
    logic [5:0]  bit_cnt;
    logic [39:0] frame;           // start, transmission, index, data
    logic        is_r3;
    logic        accept;
    logic        crc_shift;
    logic [6:0]  crc;
    logic [2:0]  crc_sel;
    logic        cur_bit;

    assign o_resp_ready = (state == TX_IDLE);
    assign accept       = i_resp_valid && o_resp_ready;
    assign o_line_busy  = accept || (state != TX_IDLE);

    assign crc_shift = (state == TX_SEND) && (bit_cnt < CRC_FIRST);
    assign crc_sel   = 3'(END_BIT - 6'd1 - bit_cnt);   // crc msb goes out first

    always_comb
    begin
        if (bit_cnt < CRC_FIRST)
            cur_bit = frame[39];
        else if (bit_cnt == END_BIT)
            cur_bit = 1'b1;
        else
            cur_bit = is_r3 | crc[crc_sel];   // R3 carries all ones here
    end

    // direction low only while the card owns the line
    assign o_cmd     = (state == TX_SEND) ? cur_bit : 1'b1;
    assign o_cmd_dir = (state != TX_SEND);

    sdcard_crc7 crc0 (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_clear(state != TX_SEND),
        .i_shift(crc_shift),
        .i_bit(frame[39]),
        .o_crc(crc)
    );

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                TX_IDLE:
                    if (accept)
                    begin
                        state   <= TX_GAP;
                        bit_cnt <= '0;
                    end
                TX_GAP:
                    if (bit_cnt == GAP_LAST)
                    begin
                        state   <= TX_SEND;
                        bit_cnt <= '0;
                    end
                    else
                        bit_cnt <= bit_cnt + 6'd1;
                TX_SEND:
                    if (bit_cnt == END_BIT)
                        state <= TX_IDLE;    // line released next cycle
                    else
                        bit_cnt <= bit_cnt + 6'd1;
                default:
                    state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            is_r3 <= (i_resp.kind == sdcard_cmd_pkg::RESP_R3);
            frame <= {2'b00,
                      (i_resp.kind == sdcard_cmd_pkg::RESP_R3) ? 6'h3f : i_resp.cmd_idx,
                      i_resp.data};
        end
        else if (crc_shift)
            frame <= {frame[38:0], 1'b1};
    end

endmodule

//--- cmdio/sdcard_cmd_rx.sv
/* command-line receiver, deserializes host frames one bit per clock
   good frames leave as a one-cycle request, bad ones are dropped silently */

`timescale 1ns/10ps

`include "sdcard_consts.svh"

module sdcard_cmd_rx (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_cmd,
    input  logic                            i_line_busy,
    output logic                            o_req_valid,
    output sdcard_cmd_pkg::sdcard_cmd_req_t o_req,
    input  logic                            i_req_ready
);

    localparam logic [5:0] LAST_BIT = 6'(`SDCARD_FRAME_BITS - 1);
    localparam logic [5:0] CRC_SPAN = 6'(`SDCARD_FRAME_BITS - 8);  // start bit through argument

    logic        rx_active;
    logic [5:0]  bit_cnt;         // index of the bit sampled this cycle
    logic [46:0] shreg;
    logic        start_det;
    logic        frame_end;
    logic        frame_ok;
    logic        crc_clear;
    logic        crc_shift;
    logic [6:0]  crc;

    // the card's own start bit must not look like a new command
    assign start_det = !rx_active && !i_line_busy && !i_cmd;
    assign frame_end = rx_active && (bit_cnt == LAST_BIT);

    assign crc_shift = start_det || (rx_active && (bit_cnt < CRC_SPAN));
    assign crc_clear = (!rx_active && !start_det) || frame_end;

    // shreg[46] start, [45] transmission, [6:0] received crc, i_cmd is the end bit
    assign frame_ok = !shreg[46] && shreg[45] && (shreg[6:0] == crc) && i_cmd;

    sdcard_crc7 crc0 (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_clear(crc_clear),
        .i_shift(crc_shift),
        .i_bit(i_cmd),
        .o_crc(crc)
    );

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            rx_active   <= 1'b0;
            bit_cnt     <= '0;
            o_req_valid <= 1'b0;
        end
        else
        begin
            // FIFO ready now stays ready next cycle, only this block writes it
            o_req_valid <= frame_end && frame_ok && i_req_ready;
            if (start_det)
            begin
                rx_active <= 1'b1;
                bit_cnt   <= 6'd1;
            end
            else if (frame_end)
                rx_active <= 1'b0;
            else if (rx_active)
                bit_cnt <= bit_cnt + 6'd1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (start_det || rx_active)
            shreg <= {shreg[45:0], i_cmd};
        if (frame_end)
        begin
            o_req.cmd_idx <= shreg[44:39];
            o_req.arg     <= shreg[38:7];
        end
    end

endmodule

//--- hdl/sdcard_crc7.sv
/* serial CRC7 (x^7 + x^3 + 1), one bit per shift
   clear before each frame, then shift the covered bits in msb first */

`timescale 1ns/10ps

module sdcard_crc7 (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_clear,
    input  logic       i_shift,
    input  logic       i_bit,
    output logic [6:0] o_crc
);

    logic feedback;

    assign feedback = i_bit ^ o_crc[6];

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_clear)
            o_crc <= '0;
        else if (i_shift)
            o_crc <= {o_crc[5:3], o_crc[2] ^ feedback, o_crc[1:0], feedback};  // taps at 3 and 0
    end

endmodule

//--- common/sdcard_state_pkg.sv
/* card-state types and R1 status layout
   reference by scoped names, sdcard_state_pkg::name */

package sdcard_state_pkg;

    // encoding matches the current_state field of R1
    typedef enum logic [3:0] {
        IDLE  = 4'd0,
        READY = 4'd1
    } sdcard_state_e;

    // bit positions inside the 32-bit card status of R1
    localparam int R1_ILLEGAL_CMD_BIT = 22;
    localparam int R1_APP_CMD_BIT     = 5;
    localparam int R1_STATE_LSB       = 9;     // 4-bit current_state field

endpackage

//--- common/sdcard_cmd_pkg.sv
/* command-frame types shared by the receiver, FIFO, controller and transmitter
   reference by scoped names, sdcard_cmd_pkg::name */

package sdcard_cmd_pkg;

    // one 32-bit argument, read two ways depending on the command
    typedef union packed {
        struct packed {
            logic [19:0] reserved;
            logic [3:0]  vhs;               // voltage host supply
            logic [7:0]  check_pattern;     // echoed back in R7
        } if_cond;                          // CMD8
        struct packed {
            logic        reserved_hi;
            logic        hcs;               // host capacity support
            logic [5:0]  reserved_lo;
            logic [23:0] vdd_window;
        } op_cond;                          // ACMD41
    } sdcard_cmd_arg_u;

    typedef struct packed {
        logic [5:0]      cmd_idx;
        sdcard_cmd_arg_u arg;
    } sdcard_cmd_req_t;

    typedef enum logic [1:0] {
        RESP_R1 = 2'd0,
        RESP_R3 = 2'd1,                     // index and crc sent as all ones
        RESP_R7 = 2'd2
    } sdcard_resp_kind_e;

    typedef struct packed {
        sdcard_resp_kind_e kind;
        logic [5:0]        cmd_idx;
        logic [31:0]       data;
    } sdcard_cmd_resp_t;

    localparam logic [5:0] CMD_GO_IDLE          = 6'd0;
    localparam logic [5:0] CMD_SEND_IF_COND     = 6'd8;
    localparam logic [5:0] CMD_APP_CMD          = 6'd55;
    localparam logic [5:0] ACMD_SD_SEND_OP_COND = 6'd41;

endpackage

//--- common/sdcard_consts.svh
/* card configuration and frame sizes for the SD card command-line model
   include in any file that needs these values */

`ifndef SDCARD_CONSTS_SVH
`define SDCARD_CONSTS_SVH

// ACMD41 commands until the card reports power-up done
`define SDCARD_POWERUP_DONE_DELAY 3

// voltage host supply code accepted by CMD8 (2.7-3.6V)
`define SDCARD_VHS 4'h1

// OCR voltage window returned in R3
`define SDCARD_VDD_VOLTAGE_WINDOW 24'hff8000

// every command and response frame on the cmd line
`define SDCARD_FRAME_BITS 48

// request FIFO between receiver and controller
`define SDCARD_REQ_FIFO_DEPTH 4

`endif
